// File: verilog/fetch_bus_pkg.sv
////////////////////
// fetch bus types
// address, instruction word and prefetch count widths
////////////////////

package fetch_bus_pkg;

  // byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] instr_t;

  // occupancy and free slots of the prefetch buffer
  // three bits cover depths up to 7
  typedef logic [2:0] fifo_cnt_t;

  ////////////////////
  // constants
  ////////////////////

  // low byte of the boot fetch address
  // the boot region itself is 256-byte aligned
  localparam logic [7:0] BootOffset = 8'h80;

  // sequential pc step, no compressed instructions
  localparam addr_t WordBytes = 32'd4;

endpackage

// File: verilog/fetch_ctrl_pkg.sv
////////////////////
// fetch control types
// redirect select encodings and the vectored interrupt cause
////////////////////

package fetch_ctrl_pkg;

  ////////////////////
  // redirect select
  ////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which vector PC_EXC resolves to
  typedef enum logic [1:0] {
    EXC_PC_EXC = 2'd0,
    EXC_PC_IRQ = 2'd1,
    EXC_PC_DBG = 2'd2
  } exc_pc_sel_e;

  ////////////////////
  // cause fields
  ////////////////////

  // interrupt number, selects the slot in a vectored mtvec table
  typedef logic [4:0] irq_cause_t;

endpackage

// File: verilog/pc_select.sv
////////////////////
// redirect target select
// builds exception vectors and picks the next fetch address
////////////////////

`timescale 1ns/1ps

module pc_select import fetch_bus_pkg::*; import fetch_ctrl_pkg::*; #(
  parameter addr_t DmHaltAddr = 32'h1A11_0800
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_cause_t  irq_cause_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        branch_o,
  output addr_t       branch_addr_o,
  output logic        csr_mtvec_init_o
);

  addr_t exc_pc;

  // exception vector mux
  // vectored irqs land at base + 4 * cause
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC: exc_pc = {csr_mtvec_i[31:8], 8'h00};
      EXC_PC_IRQ: exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_cause_i, 2'b00};
      EXC_PC_DBG: exc_pc = DmHaltAddr;
      default:    exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  // redirect target mux
  // all targets word aligned, low two bits dropped
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: branch_addr_o = {boot_addr_i[31:8], BootOffset};
      PC_JUMP: branch_addr_o = {branch_target_i[31:2], 2'b00};
      PC_EXC:  branch_addr_o = exc_pc;
      PC_ERET: branch_addr_o = {csr_mepc_i[31:2], 2'b00};
      PC_DRET: branch_addr_o = {csr_depc_i[31:2], 2'b00};
      default: branch_addr_o = {boot_addr_i[31:8], BootOffset};
    endcase
  end

  // strobe passes straight on to the fetch datapath
  assign branch_o = pc_set_i;

  // csr file inits mtvec on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  ////////////////////
  // assertions
  ////////////////////

  // boot region must be 256-byte aligned for the fixed offset
  boot_addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[7:0] == 8'h00);

  // selects must be driven whenever a redirect is requested
  sel_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown({pc_mux_i, exc_pc_mux_i}));

endmodule

// File: verilog/fetch_requester.sv
////////////////////
// instruction bus requester
// issues word fetches and drops responses of a stale stream
////////////////////

`timescale 1ns/1ps

module fetch_requester import fetch_bus_pkg::*; #(
  parameter int FifoDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      branch_i,
  input  addr_t     branch_addr_i,
  input  fifo_cnt_t free_i,
  input  logic      instr_gnt_i,
  input  logic      instr_rvalid_i,
  output logic      instr_req_o,
  output addr_t     instr_addr_o,
  output logic      push_o,
  output addr_t     push_addr_o,
  output logic      busy_o
);

  logic      started_q;
  addr_t     fetch_addr_q;
  addr_t     resp_addr_q;
  fifo_cnt_t outst_q, outst_d;
  fifo_cnt_t discard_q, discard_d;
  logic      gnt_acc;
  logic      live_rvalid;

  // no fetching before the first redirect
  // hold off new requests until stale responses are drained
  // outstanding below free slots keeps the buffer from overflowing
  assign instr_req_o  = started_q & (discard_q == '0) & (outst_q < free_i);
  assign instr_addr_o = fetch_addr_q;

  assign gnt_acc     = instr_req_o & instr_gnt_i;
  assign live_rvalid = instr_rvalid_i & (discard_q == '0);

  // a response in the redirect cycle is old stream, buffer is flushed anyway
  assign push_o      = live_rvalid & ~branch_i;
  assign push_addr_o = resp_addr_q;

  assign busy_o = (outst_q != '0) | (discard_q != '0);

  ////////////////////
  // response counters
  ////////////////////

  always_comb begin
    outst_d   = outst_q + fifo_cnt_t'(gnt_acc) - fifo_cnt_t'(live_rvalid);
    discard_d = discard_q - fifo_cnt_t'(instr_rvalid_i & (discard_q != '0));
    if (branch_i) begin
      // everything in flight now belongs to the old stream
      // a grant in this cycle is still for the old address
      outst_d   = '0;
      discard_d = discard_q + outst_q + fifo_cnt_t'(gnt_acc) - fifo_cnt_t'(instr_rvalid_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
      outst_q   <= '0;
      discard_q <= '0;
    end else begin
      started_q <= started_q | branch_i;
      outst_q   <= outst_d;
      discard_q <= discard_d;
    end
  end

  // request address and address of the oldest live response
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      fetch_addr_q <= branch_addr_i;
      resp_addr_q  <= branch_addr_i;
    end else begin
      if (gnt_acc) begin
        fetch_addr_q <= fetch_addr_q + WordBytes;
      end
      if (push_o) begin
        resp_addr_q <= resp_addr_q + WordBytes;
      end
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  req_addr_ok_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00));

  // the bus answers only what was granted
  no_stray_rvalid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> busy_o);

  // words in flight never exceed what the buffer can take
  in_flight_bound_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (int'(outst_q) + int'(discard_q)) <= FifoDepth);

endmodule

// File: verilog/fetch_fifo.sv
////////////////////
// prefetch buffer
// circular store of fetched words with address and error flag
////////////////////

`timescale 1ns/1ps

module fetch_fifo import fetch_bus_pkg::*; #(
  parameter int FifoDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      push_i,
  input  addr_t     push_addr_i,
  input  instr_t    push_rdata_i,
  input  logic      push_err_i,
  input  logic      ready_i,
  output fifo_cnt_t free_o,
  output logic      valid_o,
  output instr_t    rdata_o,
  output addr_t     addr_o,
  output logic      err_o
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(FifoDepth - 1);

  instr_t          rdata_mem [FifoDepth];
  addr_t           addr_mem  [FifoDepth];
  logic            err_mem   [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  fifo_cnt_t       count_q;
  logic            pop;

  assign valid_o = (count_q != '0);
  assign pop     = valid_o & ready_i;

  // head entry
  assign rdata_o = rdata_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];

  // slot read this cycle counts as free
  assign free_o = fifo_cnt_t'(FifoDepth) - count_q + fifo_cnt_t'(pop);

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect drops every buffered word
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + fifo_cnt_t'(push_i) - fifo_cnt_t'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      rdata_mem[wr_ptr_q] <= push_rdata_i;
      addr_mem[wr_ptr_q]  <= push_addr_i;
      err_mem[wr_ptr_q]   <= push_err_i;
    end
  end

  // requester throttling must keep a slot open for every response
  no_push_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (int'(count_q) < FifoDepth));

endmodule

// File: verilog/if_id_register.sv
////////////////////
// output register to decode
// valid/ready stage with sequential pc check
////////////////////

`timescale 1ns/1ps

module if_id_register import fetch_bus_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   branch_i,
  input  logic   valid_i,
  input  instr_t rdata_i,
  input  addr_t  addr_i,
  input  logic   err_i,
  input  logic   instr_ready_i,
  output logic   ready_o,
  output logic   instr_valid_o,
  output instr_t instr_rdata_o,
  output addr_t  instr_pc_o,
  output logic   instr_fetch_err_o,
  output logic   pc_mismatch_alert_o
);

  logic load;
  logic seq_q, seq_d;

  // take a word when empty or when decode drains us this cycle
  assign ready_o = ~instr_valid_o | instr_ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_o <= 1'b0;
    end else if (branch_i) begin
      // squash whatever is in flight towards decode
      instr_valid_o <= 1'b0;
    end else if (ready_o) begin
      instr_valid_o <= valid_i;
    end
  end

  // payload, held while decode stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_o     <= rdata_i;
      instr_pc_o        <= addr_i;
      instr_fetch_err_o <= err_i;
    end
  end

  ////////////////////
  // pc increment check
  ////////////////////

  // instr_pc_o keeps the last loaded pc
  // no check across a redirect or after a faulting fetch
  assign seq_d = (seq_q | load) & ~branch_i & ~(load & err_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_mismatch_alert_o = load & seq_q & (addr_i != instr_pc_o + WordBytes);

endmodule

// File: verilog/instr_fetch_top.sv
////////////////////
// instruction fetch front end
// target select, bus requester, prefetch buffer, decode register
////////////////////

`timescale 1ns/1ps

module instr_fetch_top import fetch_bus_pkg::*; import fetch_ctrl_pkg::*; #(
  parameter addr_t DmHaltAddr = 32'h1A11_0800,
  parameter int    FifoDepth  = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // redirect control
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_cause_t  irq_cause_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,
  // instruction memory bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,
  // towards decode
  output logic        instr_valid_o,
  output instr_t      instr_rdata_o,
  output addr_t       instr_pc_o,
  output logic        instr_fetch_err_o,
  input  logic        instr_ready_i,
  output logic        pc_mismatch_alert_o,
  output logic        busy_o
);

  logic      branch;
  addr_t     branch_addr;
  logic      push;
  addr_t     push_addr;
  fifo_cnt_t free;
  logic      fifo_valid;
  logic      fifo_ready;
  instr_t    fifo_rdata;
  addr_t     fifo_addr;
  logic      fifo_err;

  pc_select #(
    .DmHaltAddr (DmHaltAddr)
  ) u_pc_select (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_cause_i      (irq_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .branch_o         (branch),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_requester #(
    .FifoDepth (FifoDepth)
  ) u_fetch_requester (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .free_i         (free),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .push_o         (push),
    .push_addr_o    (push_addr),
    .busy_o         (busy_o)
  );

  // bus data and error go straight into the buffer
  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (branch),
    .push_i       (push),
    .push_addr_i  (push_addr),
    .push_rdata_i (instr_rdata_i),
    .push_err_i   (instr_err_i),
    .ready_i      (fifo_ready),
    .free_o       (free),
    .valid_o      (fifo_valid),
    .rdata_o      (fifo_rdata),
    .addr_o       (fifo_addr),
    .err_o        (fifo_err)
  );

  if_id_register u_if_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .branch_i            (branch),
    .valid_i             (fifo_valid),
    .rdata_i             (fifo_rdata),
    .addr_i              (fifo_addr),
    .err_i               (fifo_err),
    .instr_ready_i       (instr_ready_i),
    .ready_o             (fifo_ready),
    .instr_valid_o       (instr_valid_o),
    .instr_rdata_o       (instr_rdata_o),
    .instr_pc_o          (instr_pc_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// File: verification/tb_imem_responder.sv
////////////////////
// instruction memory model
// random grants, in-order answers after 0 to 3 cycles
////////////////////

`timescale 1ns/1ps

module tb_imem_responder import fetch_bus_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  addr_t  addr_i,
  output logic   gnt_o,
  output logic   rvalid_o,
  output instr_t rdata_o,
  output logic   err_o
);

  // granted addresses and the cycle each answer is due
  addr_t       pend_addr [$];
  int unsigned pend_due [$];
  int unsigned cycle_cnt;
  int unsigned last_due;
  int unsigned due;
  addr_t       resp_addr;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      pend_addr.delete();
      pend_due.delete();
      cycle_cnt = 0;
      last_due  = 0;
    end else begin
      cycle_cnt = cycle_cnt + 1;
      // request accepted at this edge
      if (req_i && gnt_o) begin
        due = cycle_cnt + ($urandom % 4);
        // one answer per cycle, never overtaking an older one
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
      end
      // grant about two cycles in three
      gnt_o <= ($urandom % 3) != 0;
      if ((pend_due.size() > 0) && (pend_due[0] <= cycle_cnt)) begin
        resp_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        // data is the inverted address, error where bits 7..4 are all ones
        rvalid_o <= 1'b1;
        rdata_o  <= ~resp_addr;
        err_o    <= (resp_addr[7:4] == 4'hF);
      end else begin
        rvalid_o <= 1'b0;
        rdata_o  <= '0;
        err_o    <= 1'b0;
      end
    end
  end

endmodule

// File: verification/tb_instr_fetch.sv
////////////////////
// testbench for the instruction fetch front end
// random redirects and stalls against a next-pc model
////////////////////

`timescale 1ns/1ps

module tb_instr_fetch import fetch_bus_pkg::*; import fetch_ctrl_pkg::*;;

  localparam addr_t HaltAddr      = 32'h1A11_0800;
  localparam int    Depth         = 3;
  localparam int    NumRedirects  = 400;
  localparam int    TimeoutCycles = NumRedirects * 60;
  localparam int    TailXfers     = 16;

  logic clk, rst_n;
  logic pc_set_i, csr_mtvec_init_o;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_cause_t irq_cause_i;
  addr_t boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  addr_t instr_addr_o;
  instr_t instr_rdata_i;
  logic instr_valid_o, instr_fetch_err_o, instr_ready_i, pc_mismatch_alert_o, busy_o;
  instr_t instr_rdata_o;
  addr_t instr_pc_o;

  // model state
  addr_t exp_pc;
  addr_t exp_req_addr;
  logic started, redirect_prev, done;
  int unsigned cycle_cnt, redirect_cnt, stream_xfer_cnt, bus_pending, gap;

  instr_fetch_top #(
    .DmHaltAddr (HaltAddr),
    .FifoDepth  (Depth)
  ) u_instr_fetch_top (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_cause_i         (irq_cause_i),
    .boot_addr_i         (boot_addr_i),
    .branch_target_i     (branch_target_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_err_i         (instr_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_rdata_o       (instr_rdata_o),
    .instr_pc_o          (instr_pc_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .instr_ready_i       (instr_ready_i),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .busy_o              (busy_o)
  );

  tb_imem_responder u_imem (
    .clk_i (clk), .rst_ni (rst_n), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i),
    .err_o (instr_err_i)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // fetch target for a redirect, built from the address rules
  function automatic addr_t redirect_target(input pc_sel_e sel, input exc_pc_sel_e esel);
    case (sel)
      PC_BOOT: return (boot_addr_i & 32'hFFFF_FF00) | 32'h0000_0080;
      PC_JUMP: return branch_target_i & ~32'h3;
      PC_ERET: return csr_mepc_i & ~32'h3;
      PC_DRET: return csr_depc_i & ~32'h3;
      default: begin
        if (esel == EXC_PC_DBG) return HaltAddr;
        else if (esel == EXC_PC_IRQ) return (csr_mtvec_i & ~32'hFF) | (addr_t'(irq_cause_i) << 2);
        else return csr_mtvec_i & ~32'hFF;
      end
    endcase
  endfunction

  // random word-aligned address
  function automatic addr_t rand_word();
    addr_t a;
    a = $urandom;
    a[1:0] = 2'b00;
    return a;
  endfunction

  ////////////////////
  // per-cycle checks on pre-edge values
  ////////////////////

  task automatic check_cycle();
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("timeout, the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAIL");
      $fatal(1);
    end
    check_bit("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
    check_bit("csr_mtvec_init_o", csr_mtvec_init_o, pc_set_i && (pc_mux_i == PC_BOOT));
    // granted requests still waiting for an answer keep the block busy
    check_bit("busy_o", busy_o, bus_pending != 0);
    if (!started) check_bit("instr_req_o", instr_req_o, 1'b0);
    // register squashed at the redirect edge
    if (redirect_prev) check_bit("instr_valid_o", instr_valid_o, 1'b0);
    // accepted request, addresses step one word at a time from the target
    if (instr_req_o && instr_gnt_i) begin
      check_addr("instr_addr_o", instr_addr_o, exp_req_addr);
      exp_req_addr = exp_req_addr + 32'd4;
      bus_pending++;
    end
    if (instr_rvalid_i) bus_pending--;
    // transfer to decode, same-cycle transfer still uses the old stream
    if (instr_valid_o && instr_ready_i) begin
      if (!started) begin
        $display("an instruction reached decode before the first redirect");
        $display("TEST FAIL");
        $fatal(1);
      end
      check_addr("instr_pc_o", instr_pc_o, exp_pc);
      check_instr("instr_rdata_o", instr_rdata_o, ~exp_pc);
      check_bit("instr_fetch_err_o", instr_fetch_err_o, exp_pc[7:4] == 4'hF);
      exp_pc = exp_pc + 32'd4;
      stream_xfer_cnt++;
    end
    redirect_prev = pc_set_i;
    if (pc_set_i) begin
      exp_pc          = redirect_target(pc_mux_i, exc_pc_mux_i);
      exp_req_addr    = exp_pc;
      stream_xfer_cnt = 0;
      started         = 1'b1;
    end
  endtask

  // next-cycle stimulus, first redirect is always boot
  task automatic drive_cycle();
    addr_t rnd;
    instr_ready_i <= ($urandom % 4) != 0;
    if ((redirect_cnt < NumRedirects) && (gap == 0)) begin
      rnd = $urandom;
      pc_set_i        <= 1'b1;
      pc_mux_i        <= (redirect_cnt == 0) ? PC_BOOT : pc_sel_e'($urandom % 5);
      exc_pc_mux_i    <= exc_pc_sel_e'($urandom % 3);
      irq_cause_i     <= irq_cause_t'($urandom);
      boot_addr_i     <= {rnd[31:8], 8'h00};
      branch_target_i <= rand_word();
      csr_mepc_i      <= rand_word();
      csr_depc_i      <= rand_word();
      csr_mtvec_i     <= rand_word();
      redirect_cnt++;
      gap = 10 + ($urandom % 21);
    end else begin
      pc_set_i <= 1'b0;
      if (gap > 0) gap--;
      // the last stream has to deliver a few words before the end
      done = (redirect_cnt == NumRedirects) && (stream_xfer_cnt >= TailXfers);
    end
  endtask

  initial begin
    void'($urandom(32'h2a8));
    clk = 1'b0;
    rst_n = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    irq_cause_i = '0;
    boot_addr_i = '0;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    csr_mtvec_i = '0;
    instr_ready_i = 1'b0;
    exp_pc = '0;
    exp_req_addr = '0;
    started = 1'b0;
    redirect_prev = 1'b0;
    done = 1'b0;
    cycle_cnt = 0;
    redirect_cnt = 0;
    stream_xfer_cnt = 0;
    bus_pending = 0;
    gap = 3;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (!done) begin
      @(posedge clk);
      check_cycle();
      drive_cycle();
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: compile.f
verilog/fetch_bus_pkg.sv
verilog/fetch_ctrl_pkg.sv
verilog/pc_select.sv
verilog/fetch_requester.sv
verilog/fetch_fifo.sv
verilog/if_id_register.sv
verilog/instr_fetch_top.sv
verification/tb_imem_responder.sv
verification/tb_instr_fetch.sv
